// ==== common/sched_config.svh ====
// Scheduler sizing macros, included by the package and by RTL that needs the task lengths
`ifndef SCHED_CONFIG_SVH
`define SCHED_CONFIG_SVH

// ==================================================
// Tick counter
// ==================================================

// Width of the per-machine tick counter
`define SCHED_CNT_W 3

// ==================================================
// Task lengths
// ==================================================

// Short task frees on its 2nd accepted tick
`define SCHED_SHORT_LAST 1
// Long task frees on its 3rd accepted tick
`define SCHED_LONG_LAST 2

`endif

// ==== common/sched_pkg.sv ====
// Shared scheduler types, referenced by scoped name from every RTL module
`include "sched_config.svh"

package sched_pkg;

  // ==================================================
  // Task and event types
  // ==================================================

  // Kind of task held by a machine
  typedef enum logic [1:0] {
    TASK_IDLE = 2'd0,
    TASK_A    = 2'd1,
    TASK_B    = 2'd2
  } task_kind_e;

  // Raw strobes in, accepted strobes out
  typedef struct packed {
    logic start_a;
    logic start_b;
    logic tick;
  } sched_event_t;

  // External placement levels
  typedef struct packed {
    logic to_m0;
    logic to_m1;
  } grant_t;

  // ==================================================
  // Buffer observation and machine state
  // ==================================================

  // Buffer signals watched by the mode automata
  typedef struct packed {
    logic btor_req0;
    logic btor_req1;
    logic n_empty;
    logic deq;
  } bus_obs_t;

  // Occupancy plus tick count of one machine
  typedef struct packed {
    task_kind_e              kind;
    logic [`SCHED_CNT_W-1:0] count;
  } machine_status_t;

  // Short-task mode per machine
  typedef struct packed {
    logic short_m0;
    logic short_m1;
  } machine_mode_t;

endpackage

// ==== source/event_arbiter.sv ====
// Event arbiter, arms one edge after reset and picks start A, then start B, then tick
`timescale 1ns/1ps

module event_arbiter (
  input  logic                    clk,
  input  logic                    i_arst_n,
  input  sched_pkg::sched_event_t i_event,
  input  logic                    i_error,
  output sched_pkg::sched_event_t o_accepted,
  output logic                    o_armed
);

  logic armed_q;
  logic start_ok;
  logic acc_start_a;
  logic acc_start_b;
  logic acc_tick;

  // ==================================================
  // Arming
  // ==================================================

  // Low out of reset, high from the first edge on
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      armed_q <= 1'b0;
    end else begin
      armed_q <= 1'b1;
    end
  end

  // ==================================================
  // Fixed priority
  // ==================================================

  // Starts are refused once the error is set
  assign start_ok    = armed_q & ~i_error;
  assign acc_start_a = start_ok & i_event.start_a;
  // B only when A is not taken this cycle
  assign acc_start_b = start_ok & ~acc_start_a & i_event.start_b;
  // Tick still passes after an error
  assign acc_tick    = armed_q & ~acc_start_a & ~acc_start_b & i_event.tick;

  assign o_accepted.start_a = acc_start_a;
  assign o_accepted.start_b = acc_start_b;
  assign o_accepted.tick    = acc_tick;
  assign o_armed            = armed_q;

endmodule

// ==== scheduler/dispatch_ctrl.sv ====
// Dispatcher, routes accepted starts to a machine by grant and holds the sticky error
`timescale 1ns/1ps

module dispatch_ctrl (
  input  logic                       clk,
  input  logic                       i_arst_n,
  input  logic                       i_armed,
  input  sched_pkg::sched_event_t    i_accepted,
  input  sched_pkg::grant_t          i_grant,
  input  sched_pkg::machine_status_t i_status_m0,
  input  sched_pkg::machine_status_t i_status_m1,
  output sched_pkg::task_kind_e      o_start_m0,
  output sched_pkg::task_kind_e      o_start_m1,
  output logic                       o_error
);

  sched_pkg::task_kind_e start_kind;
  logic                  any_start;
  logic                  busy_m0;
  logic                  busy_m1;
  logic                  sel_m0;
  logic                  sel_m1;
  logic                  err_busy;
  logic                  err_nogrant;
  logic                  error_q;

  // ==================================================
  // Start routing
  // ==================================================

  // Arbiter guarantees at most one start per cycle
  always_comb begin
    if (i_accepted.start_a) begin
      start_kind = sched_pkg::TASK_A;
    end else if (i_accepted.start_b) begin
      start_kind = sched_pkg::TASK_B;
    end else begin
      start_kind = sched_pkg::TASK_IDLE;
    end
  end

  assign any_start = i_accepted.start_a | i_accepted.start_b;

  // Machine 0 wins when both grants are up
  assign sel_m0 = i_grant.to_m0;
  assign sel_m1 = ~i_grant.to_m0 & i_grant.to_m1;

  // Idle kind means no start for that machine
  assign o_start_m0 = sel_m0 ? start_kind : sched_pkg::TASK_IDLE;
  assign o_start_m1 = sel_m1 ? start_kind : sched_pkg::TASK_IDLE;

  // ==================================================
  // Sticky scheduling error
  // ==================================================

  assign busy_m0 = (i_status_m0.kind != sched_pkg::TASK_IDLE);
  assign busy_m1 = (i_status_m1.kind != sched_pkg::TASK_IDLE);

  // Grant level on a busy machine, start or not
  assign err_busy    = (i_grant.to_m0 & busy_m0) | (i_grant.to_m1 & busy_m1);
  // Start with nowhere to go
  assign err_nogrant = any_start & ~i_grant.to_m0 & ~i_grant.to_m1;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      error_q <= 1'b0;
    end else if (i_armed && (err_busy || err_nogrant)) begin
      // Held until the next reset
      error_q <= 1'b1;
    end
  end

  assign o_error = error_q;

endmodule

// ==== scheduler/machine_timer.sv ====
// Machine timer, tracks the task held by one machine and frees it after its tick count
`timescale 1ns/1ps
`include "sched_config.svh"

module machine_timer (
  input  logic                       clk,
  input  logic                       i_arst_n,
  input  sched_pkg::task_kind_e      i_start,
  input  logic                       i_tick,
  input  logic                       i_short,
  output sched_pkg::machine_status_t o_status
);

  localparam logic [`SCHED_CNT_W-1:0] SHORT_LAST = `SCHED_SHORT_LAST;
  localparam logic [`SCHED_CNT_W-1:0] LONG_LAST  = `SCHED_LONG_LAST;

  sched_pkg::machine_status_t status_q;
  logic [`SCHED_CNT_W-1:0]    last_cnt;
  logic                       busy;
  logic                       load;

  // Mode picks the final count value, sampled at each tick
  assign last_cnt = i_short ? SHORT_LAST : LONG_LAST;
  assign busy     = (status_q.kind != sched_pkg::TASK_IDLE);
  assign load     = (i_start != sched_pkg::TASK_IDLE);

  // ==================================================
  // Occupancy and count
  // ==================================================

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      status_q.kind  <= sched_pkg::TASK_IDLE;
      status_q.count <= '0;
    end else if (load) begin
      // New task, overwrites whatever was running
      status_q.kind  <= i_start;
      status_q.count <= '0;
    end else if (i_tick && busy) begin
      if (status_q.count < last_cnt) begin
        // Not done yet
        status_q.count <= status_q.count + 1'b1;
      end else begin
        // Done, machine free again
        status_q.kind  <= sched_pkg::TASK_IDLE;
        status_q.count <= '0;
      end
    end
  end

  // Ticks on an idle machine leave it unchanged

  assign o_status = status_q;

endmodule

// ==== bus_automata/bus_mode_fsm.sv ====
// Buffer-watching automata that set the short-task mode bit of each machine
`timescale 1ns/1ps

module bus_mode_fsm (
  input  logic                     clk,
  input  logic                     i_arst_n,
  input  sched_pkg::bus_obs_t      i_bus,
  output sched_pkg::machine_mode_t o_mode
);

  sched_pkg::bus_obs_t bus_q;
  // Request-order automaton, low bit and complemented high bit
  logic                state_ro_0;
  logic                nstate_ro_1;
  // Pending-dequeue automaton
  logic                state_pd;

  // ==================================================
  // Previous bus values
  // ==================================================

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      bus_q <= '0;
    end else begin
      bus_q <= i_bus;
    end
  end

  // ==================================================
  // Request-order automaton
  // ==================================================

  // Steps from the registered requests, so one edge behind bus_q
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      nstate_ro_1 <= 1'b0;
      state_ro_0  <= 1'b0;
    end else if (nstate_ro_1 && !bus_q.btor_req0 && bus_q.btor_req1) begin
      // Request 1 alone
      nstate_ro_1 <= 1'b0;
      state_ro_0  <= 1'b0;
    end else if (!nstate_ro_1 && bus_q.btor_req0 && !bus_q.btor_req1) begin
      // Request 0 alone
      nstate_ro_1 <= 1'b1;
      state_ro_0  <= 1'b0;
    end else if (nstate_ro_1 && !bus_q.btor_req0 && !bus_q.btor_req1) begin
      nstate_ro_1 <= 1'b1;
      state_ro_0  <= 1'b1;
    end else if (!nstate_ro_1 && !bus_q.btor_req0 && !bus_q.btor_req1) begin
      nstate_ro_1 <= 1'b0;
      state_ro_0  <= 1'b1;
    end
  end

  // Any other request mix holds the state

  // ==================================================
  // Pending-dequeue automaton
  // ==================================================

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_pd <= 1'b0;
    end else if (!state_pd && bus_q.n_empty && !bus_q.deq) begin
      // Data waiting, no dequeue yet
      state_pd <= 1'b1;
    end else if (state_pd && bus_q.deq) begin
      state_pd <= 1'b0;
    end
  end

  // Mode outputs
  assign o_mode.short_m0 = state_ro_0;
  assign o_mode.short_m1 = nstate_ro_1 | state_pd;

endmodule

// ==== source/sched_top.sv ====
// Scheduler top level, connects arbiter, dispatcher, both machine timers and mode automata
`timescale 1ns/1ps

module sched_top (
  input  logic                       clk,
  input  logic                       i_arst_n,
  input  sched_pkg::sched_event_t    i_event,
  input  sched_pkg::grant_t          i_grant,
  input  sched_pkg::bus_obs_t        i_bus,
  output sched_pkg::sched_event_t    o_accepted,
  output logic                       o_error,
  output sched_pkg::machine_status_t o_status_m0,
  output sched_pkg::machine_status_t o_status_m1
);

  sched_pkg::sched_event_t    accepted;
  sched_pkg::task_kind_e      start_m0;
  sched_pkg::task_kind_e      start_m1;
  sched_pkg::machine_status_t status_m0;
  sched_pkg::machine_status_t status_m1;
  sched_pkg::machine_mode_t   mode;
  logic                       armed;
  logic                       error;

  // ==================================================
  // Event acceptance and dispatch
  // ==================================================

  event_arbiter event_arbiter_inst (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_event    (i_event),
    .i_error    (error),
    .o_accepted (accepted),
    .o_armed    (armed)
  );

  dispatch_ctrl dispatch_ctrl_inst (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_armed     (armed),
    .i_accepted  (accepted),
    .i_grant     (i_grant),
    .i_status_m0 (status_m0),
    .i_status_m1 (status_m1),
    .o_start_m0  (start_m0),
    .o_start_m1  (start_m1),
    .o_error     (error)
  );

  // ==================================================
  // Machines and their mode source
  // ==================================================

  bus_mode_fsm bus_mode_fsm_inst (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_bus    (i_bus),
    .o_mode   (mode)
  );

  // Machine 0
  machine_timer machine_timer_m0_inst (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_start  (start_m0),
    .i_tick   (accepted.tick),
    .i_short  (mode.short_m0),
    .o_status (status_m0)
  );

  // Machine 1
  machine_timer machine_timer_m1_inst (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_start  (start_m1),
    .i_tick   (accepted.tick),
    .i_short  (mode.short_m1),
    .o_status (status_m1)
  );

  assign o_accepted  = accepted;
  assign o_error     = error;
  assign o_status_m0 = status_m0;
  assign o_status_m1 = status_m1;

endmodule

// ==== verification/sched_tb_table.svh ====
// Scheduler test rows, included into the testbench row loader and applied in order
// Columns: op, event {a,b,tick}, grant {m0,m1}, bus {req0,req1,n_empty,deq},
//          expected accepted, expected error, m0 kind, m0 count, m1 kind, m1 count

// ==================================================
// Arming, priority, short m0 and long m1
// ==================================================
rows.push_back(make_row(OP_RESET, 3'b000, 2'b00, 4'b0000, 3'b000, 1'b0, 0, 0, 0, 0));
// First edge after reset, nothing taken
rows.push_back(make_row(OP_CYCLE, 3'b111, 2'b00, 4'b0000, 3'b000, 1'b0, 0, 0, 0, 0));
// A masks B and tick
rows.push_back(make_row(OP_CYCLE, 3'b111, 2'b10, 4'b0000, 3'b100, 1'b0, 1, 0, 0, 0));
// B masks tick
rows.push_back(make_row(OP_CYCLE, 3'b011, 2'b01, 4'b0000, 3'b010, 1'b0, 1, 0, 2, 0));
rows.push_back(make_row(OP_GAP,   3'b001, 2'b00, 4'b0000, 3'b001, 1'b0, 1, 1, 2, 1));
// Short task gone after two ticks
rows.push_back(make_row(OP_GAP,   3'b001, 2'b00, 4'b0000, 3'b001, 1'b0, 0, 0, 2, 2));
// Long task gone after three
rows.push_back(make_row(OP_GAP,   3'b001, 2'b00, 4'b0000, 3'b001, 1'b0, 0, 0, 0, 0));
// Tick on idle machines
rows.push_back(make_row(OP_CYCLE, 3'b001, 2'b00, 4'b0000, 3'b001, 1'b0, 0, 0, 0, 0));

// ==================================================
// Mode swap with btor_req0 held
// ==================================================
rows.push_back(make_row(OP_CYCLE, 3'b000, 2'b00, 4'b1000, 3'b000, 1'b0, 0, 0, 0, 0));
rows.push_back(make_row(OP_CYCLE, 3'b000, 2'b00, 4'b1000, 3'b000, 1'b0, 0, 0, 0, 0));
rows.push_back(make_row(OP_CYCLE, 3'b100, 2'b10, 4'b1000, 3'b100, 1'b0, 1, 0, 0, 0));
rows.push_back(make_row(OP_CYCLE, 3'b010, 2'b01, 4'b1000, 3'b010, 1'b0, 1, 0, 2, 0));
rows.push_back(make_row(OP_GAP,   3'b001, 2'b00, 4'b1000, 3'b001, 1'b0, 1, 1, 2, 1));
rows.push_back(make_row(OP_GAP,   3'b001, 2'b00, 4'b1000, 3'b001, 1'b0, 1, 2, 0, 0));
rows.push_back(make_row(OP_GAP,   3'b001, 2'b00, 4'b1000, 3'b001, 1'b0, 0, 0, 0, 0));

// ==================================================
// Request 1 alone and the pending dequeue
// ==================================================
// Request 1 with data waiting
rows.push_back(make_row(OP_CYCLE, 3'b000, 2'b00, 4'b0110, 3'b000, 1'b0, 0, 0, 0, 0));
// Both long again, pending dequeue makes m1 short
rows.push_back(make_row(OP_CYCLE, 3'b100, 2'b10, 4'b0100, 3'b100, 1'b0, 1, 0, 0, 0));
rows.push_back(make_row(OP_CYCLE, 3'b010, 2'b01, 4'b0100, 3'b010, 1'b0, 1, 0, 2, 0));
rows.push_back(make_row(OP_GAP,   3'b001, 2'b00, 4'b0100, 3'b001, 1'b0, 1, 1, 2, 1));
rows.push_back(make_row(OP_GAP,   3'b001, 2'b00, 4'b0100, 3'b001, 1'b0, 1, 2, 0, 0));
rows.push_back(make_row(OP_GAP,   3'b001, 2'b00, 4'b0100, 3'b001, 1'b0, 0, 0, 0, 0));
// Dequeue clears the pending state, m1 long again
rows.push_back(make_row(OP_CYCLE, 3'b000, 2'b00, 4'b0101, 3'b000, 1'b0, 0, 0, 0, 0));
rows.push_back(make_row(OP_CYCLE, 3'b010, 2'b01, 4'b0100, 3'b010, 1'b0, 0, 0, 2, 0));
rows.push_back(make_row(OP_GAP,   3'b001, 2'b00, 4'b0100, 3'b001, 1'b0, 0, 0, 2, 1));
rows.push_back(make_row(OP_GAP,   3'b001, 2'b00, 4'b0100, 3'b001, 1'b0, 0, 0, 2, 2));
rows.push_back(make_row(OP_GAP,   3'b001, 2'b00, 4'b0100, 3'b001, 1'b0, 0, 0, 0, 0));

// ==================================================
// Error from a start with no grant
// ==================================================
rows.push_back(make_row(OP_RESET, 3'b000, 2'b00, 4'b0000, 3'b000, 1'b0, 0, 0, 0, 0));
rows.push_back(make_row(OP_CYCLE, 3'b000, 2'b00, 4'b0000, 3'b000, 1'b0, 0, 0, 0, 0));
rows.push_back(make_row(OP_CYCLE, 3'b100, 2'b10, 4'b0000, 3'b100, 1'b0, 1, 0, 0, 0));
rows.push_back(make_row(OP_CYCLE, 3'b010, 2'b00, 4'b0000, 3'b010, 1'b1, 1, 0, 0, 0));
// Starts refused, tick still taken
rows.push_back(make_row(OP_CYCLE, 3'b111, 2'b00, 4'b0000, 3'b001, 1'b1, 1, 1, 0, 0));
rows.push_back(make_row(OP_CYCLE, 3'b100, 2'b01, 4'b0000, 3'b000, 1'b1, 1, 1, 0, 0));
rows.push_back(make_row(OP_DRAIN, 3'b001, 2'b00, 4'b0000, 3'b001, 1'b1, 0, 0, 0, 0));

// ==================================================
// Error from a grant level on a busy machine
// ==================================================
rows.push_back(make_row(OP_RESET, 3'b000, 2'b00, 4'b0000, 3'b000, 1'b0, 0, 0, 0, 0));
rows.push_back(make_row(OP_CYCLE, 3'b000, 2'b00, 4'b0000, 3'b000, 1'b0, 0, 0, 0, 0));
rows.push_back(make_row(OP_CYCLE, 3'b100, 2'b10, 4'b0000, 3'b100, 1'b0, 1, 0, 0, 0));
// No start, grant alone is enough
rows.push_back(make_row(OP_CYCLE, 3'b000, 2'b10, 4'b0000, 3'b000, 1'b1, 1, 0, 0, 0));
rows.push_back(make_row(OP_CYCLE, 3'b010, 2'b01, 4'b0000, 3'b000, 1'b1, 1, 0, 0, 0));
rows.push_back(make_row(OP_CYCLE, 3'b001, 2'b00, 4'b0000, 3'b001, 1'b1, 1, 1, 0, 0));
rows.push_back(make_row(OP_CYCLE, 3'b001, 2'b00, 4'b0000, 3'b001, 1'b1, 0, 0, 0, 0));

// ==== verification/sched_tb.sv ====
// Scheduler testbench, applies the row table to sched_top and checks against a cycle model
`timescale 1ns/1ps
`include "sched_config.svh"

module sched_tb;

  localparam logic [1:0] OP_CYCLE = 2'd0;
  localparam logic [1:0] OP_RESET = 2'd1;
  localparam logic [1:0] OP_GAP   = 2'd2;
  localparam logic [1:0] OP_DRAIN = 2'd3;
  // Max drain ticks before giving up
  localparam int DRAIN_LIMIT = 8;

  // One table row
  typedef struct packed {
    logic [1:0]                 op;
    sched_pkg::sched_event_t    ev;
    sched_pkg::grant_t          grant;
    sched_pkg::bus_obs_t        bus;
    sched_pkg::sched_event_t    exp_acc;
    logic                       exp_err;
    sched_pkg::machine_status_t exp_m0;
    sched_pkg::machine_status_t exp_m1;
  } row_t;

  logic                       clk;
  logic                       i_arst_n;
  sched_pkg::sched_event_t    i_event;
  sched_pkg::grant_t          i_grant;
  sched_pkg::bus_obs_t        i_bus;
  sched_pkg::sched_event_t    o_accepted;
  logic                       o_error;
  sched_pkg::machine_status_t o_status_m0;
  sched_pkg::machine_status_t o_status_m1;

  row_t   rows[$];
  integer seed = 32'h902a;
  int     check_count = 0;
  int     error_count = 0;
  logic   aborted = 1'b0;

  // Reference model state
  logic                       m_armed;
  logic                       m_error;
  sched_pkg::machine_status_t m_stat_m0;
  sched_pkg::machine_status_t m_stat_m1;
  sched_pkg::bus_obs_t        m_bus_q;
  logic                       m_ro_low;
  logic                       m_ro_high_n;
  logic                       m_pend;

  sched_top sched_top_inst (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_event     (i_event),
    .i_grant     (i_grant),
    .i_bus       (i_bus),
    .o_accepted  (o_accepted),
    .o_error     (o_error),
    .o_status_m0 (o_status_m0),
    .o_status_m1 (o_status_m1)
  );

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ==================================================
  // Table and checking helpers
  // ==================================================

  function automatic row_t make_row(input logic [1:0] op, input logic [2:0] ev,
                                    input logic [1:0] gr, input logic [3:0] bus,
                                    input logic [2:0] acc, input logic err,
                                    input int k0, input int c0, input int k1, input int c1);
    row_t r;
    r.op      = op;
    r.ev      = ev;
    r.grant   = gr;
    r.bus     = bus;
    r.exp_acc = acc;
    r.exp_err = err;
    r.exp_m0  = {k0[1:0], c0[`SCHED_CNT_W-1:0]};
    r.exp_m1  = {k1[1:0], c1[`SCHED_CNT_W-1:0]};
    return r;
  endfunction

  task automatic load_rows();
    `include "sched_tb_table.svh"
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("** Error at time %0t: %s, got 'h%0h, expected 'h%0h", $time, what, got, exp);
    end
  endtask

  // ==================================================
  // Cycle model from the scheduling rules
  // ==================================================

  function automatic sched_pkg::sched_event_t predict_accept(input sched_pkg::sched_event_t ev);
    sched_pkg::sched_event_t acc;
    acc.start_a = m_armed && !m_error && ev.start_a;
    acc.start_b = m_armed && !m_error && !acc.start_a && ev.start_b;
    acc.tick    = m_armed && !acc.start_a && !acc.start_b && ev.tick;
    return acc;
  endfunction

  function automatic sched_pkg::machine_status_t next_machine(
      input sched_pkg::machine_status_t cur, input sched_pkg::task_kind_e start,
      input logic tick, input logic short_mode);
    sched_pkg::machine_status_t nxt;
    int                         last;
    nxt  = cur;
    last = short_mode ? `SCHED_SHORT_LAST : `SCHED_LONG_LAST;
    if (start != sched_pkg::TASK_IDLE) begin
      nxt.kind  = start;
      nxt.count = '0;
    end else if (tick && cur.kind != sched_pkg::TASK_IDLE) begin
      if (cur.count < last) begin
        nxt.count = cur.count + 1'b1;
      end else begin
        nxt.kind  = sched_pkg::TASK_IDLE;
        nxt.count = '0;
      end
    end
    return nxt;
  endfunction

  task automatic clear_model();
    m_armed     = 1'b0;
    m_error     = 1'b0;
    m_stat_m0   = '0;
    m_stat_m1   = '0;
    m_bus_q     = '0;
    m_ro_low    = 1'b0;
    m_ro_high_n = 1'b0;
    m_pend      = 1'b0;
  endtask

  // One clock edge of the model, from the pre-edge state
  task automatic advance_model(input sched_pkg::sched_event_t ev, input sched_pkg::grant_t gr,
                               input sched_pkg::bus_obs_t bus);
    sched_pkg::sched_event_t acc;
    sched_pkg::task_kind_e   kind;
    logic                    start;
    logic                    busy0;
    logic                    busy1;
    logic                    short0;
    logic                    short1;
    acc    = predict_accept(ev);
    start  = acc.start_a | acc.start_b;
    kind   = acc.start_a ? sched_pkg::TASK_A :
             (acc.start_b ? sched_pkg::TASK_B : sched_pkg::TASK_IDLE);
    busy0  = (m_stat_m0.kind != sched_pkg::TASK_IDLE);
    busy1  = (m_stat_m1.kind != sched_pkg::TASK_IDLE);
    short0 = m_ro_low;
    short1 = m_ro_high_n | m_pend;
    // Three error sources, only while armed
    if (m_armed && ((gr.to_m0 && busy0) || (gr.to_m1 && busy1) ||
                    (start && !gr.to_m0 && !gr.to_m1))) begin
      m_error = 1'b1;
    end
    m_stat_m0 = next_machine(m_stat_m0, gr.to_m0 ? kind : sched_pkg::TASK_IDLE,
                             acc.tick, short0);
    m_stat_m1 = next_machine(m_stat_m1, (!gr.to_m0 && gr.to_m1) ? kind : sched_pkg::TASK_IDLE,
                             acc.tick, short1);
    // Request order, keyed on {high_n, req0, req1}
    case ({m_ro_high_n, m_bus_q.btor_req0, m_bus_q.btor_req1})
      3'b101: begin
        m_ro_high_n = 1'b0;
        m_ro_low    = 1'b0;
      end
      3'b010: begin
        m_ro_high_n = 1'b1;
        m_ro_low    = 1'b0;
      end
      3'b100: begin
        m_ro_high_n = 1'b1;
        m_ro_low    = 1'b1;
      end
      3'b000: begin
        m_ro_high_n = 1'b0;
        m_ro_low    = 1'b1;
      end
      default: begin
      end
    endcase
    // Pending dequeue
    if (!m_pend && m_bus_q.n_empty && !m_bus_q.deq) begin
      m_pend = 1'b1;
    end else if (m_pend && m_bus_q.deq) begin
      m_pend = 1'b0;
    end
    m_bus_q = bus;
    m_armed = 1'b1;
  endtask

  // ==================================================
  // Stimulus tasks
  // ==================================================

  // Called at 1 ns after an edge, or at time zero
  task automatic apply_reset();
    i_arst_n = 1'b0;
    i_event  = '0;
    i_grant  = '0;
    i_bus    = '0;
    clear_model();
    repeat (3) @(posedge clk);
    #1;
    i_arst_n = 1'b1;
  endtask

  // Drive at edge+1, sample accepted at edge+3, status at next edge+1
  task automatic run_cycle(input sched_pkg::sched_event_t ev, input sched_pkg::grant_t gr,
                           input sched_pkg::bus_obs_t bus, output sched_pkg::sched_event_t got_acc);
    sched_pkg::sched_event_t exp_acc;
    i_event = ev;
    i_grant = gr;
    i_bus   = bus;
    exp_acc = predict_accept(ev);
    #2;
    got_acc = o_accepted;
    check_value("accepted vs model", got_acc, exp_acc);
    @(posedge clk);
    advance_model(ev, gr, bus);
    #1;
    check_value("error vs model", o_error, m_error);
    check_value("status m0 vs model", o_status_m0, m_stat_m0);
    check_value("status m1 vs model", o_status_m1, m_stat_m1);
  endtask

  // Zero to three quiet cycles
  task automatic idle_gap(input sched_pkg::bus_obs_t bus);
    sched_pkg::sched_event_t got_acc;
    int                      gap;
    gap = $random(seed) & 32'h3;
    repeat (gap) run_cycle('0, '0, bus, got_acc);
  endtask

  // Keep ticking until both machines are idle
  task automatic drain_machines(input row_t row, input int idx,
                                output sched_pkg::sched_event_t got_acc);
    int cycles;
    cycles  = 0;
    got_acc = '0;
    while ((o_status_m0.kind != sched_pkg::TASK_IDLE ||
            o_status_m1.kind != sched_pkg::TASK_IDLE) && cycles < DRAIN_LIMIT) begin
      idle_gap(row.bus);
      run_cycle(row.ev, row.grant, row.bus, got_acc);
      cycles++;
    end
    if (o_status_m0.kind != sched_pkg::TASK_IDLE ||
        o_status_m1.kind != sched_pkg::TASK_IDLE) begin
      $display("Timeout: machines still busy after %0d drain ticks in row %0d", cycles, idx);
      error_count++;
      aborted = 1'b1;
    end
  endtask

  task automatic check_row(input row_t row, input int idx,
                           input sched_pkg::sched_event_t got_acc);
    check_value($sformatf("row %0d accepted", idx), got_acc, row.exp_acc);
    check_value($sformatf("row %0d error", idx), o_error, row.exp_err);
    check_value($sformatf("row %0d status m0", idx), o_status_m0, row.exp_m0);
    check_value($sformatf("row %0d status m1", idx), o_status_m1, row.exp_m1);
  endtask

  // ==================================================
  // Main sequence
  // ==================================================

  initial begin
    row_t                    row;
    sched_pkg::sched_event_t got_acc;
    int                      idx;
    i_arst_n = 1'b0;
    i_event  = '0;
    i_grant  = '0;
    i_bus    = '0;
    clear_model();
    load_rows();
    idx = 0;
    while (idx < rows.size() && !aborted) begin
      row = rows[idx];
      case (row.op)
        OP_RESET: begin
          apply_reset();
        end
        OP_GAP: begin
          idle_gap(row.bus);
          run_cycle(row.ev, row.grant, row.bus, got_acc);
          check_row(row, idx, got_acc);
        end
        OP_DRAIN: begin
          drain_machines(row, idx, got_acc);
          check_row(row, idx, got_acc);
        end
        default: begin
          run_cycle(row.ev, row.grant, row.bus, got_acc);
          check_row(row, idx, got_acc);
        end
      endcase
      idx++;
    end
    $display("Summary: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+common
+incdir+verification
common/sched_pkg.sv
source/event_arbiter.sv
scheduler/dispatch_ctrl.sv
scheduler/machine_timer.sv
bus_automata/bus_mode_fsm.sv
source/sched_top.sv
verification/sched_tb.sv
